// ==== design/soc_mem_pkg.sv ====
`default_nettype none

package soc_mem_pkg;

  //////////////////////////////////////////////////
  // Address map
  //////////////////////////////////////////////////

  localparam logic [31:0] RAM_BASE        = 32'h4000_0000;
  localparam logic [31:0] RAM_REGION_MASK = 32'h000F_FFFF;
  localparam logic [31:0] TIMER_LO_ADDR   = 32'h3000_0000;
  localparam logic [31:0] TIMER_HI_ADDR   = 32'h3000_0004;

  // First byte of a loader frame
  localparam logic [7:0]  LOAD_SYNC       = 8'hA5;

  //////////////////////////////////////////////////
  // Bus address, two decodings of one word
  //////////////////////////////////////////////////

  // RAM location: 1 MB region, word index inside it
  typedef struct packed {
    logic [11:0] tag;
    logic [17:0] widx;
    logic [1:0]  boff;
  } ram_view_t;

  // I/O location: 64 kB page of word registers
  typedef struct packed {
    logic [15:0] page;
    logic [13:0] ridx;
    logic [1:0]  boff;
  } io_view_t;

  typedef union packed {
    ram_view_t ram_view;
    io_view_t  io_view;
  } mem_addr_u;

  //////////////////////////////////////////////////
  // Bus transfer and RAM write port
  //////////////////////////////////////////////////

  // Zero wstrb marks a read
  typedef struct packed {
    logic        valid;
    logic [3:0]  wstrb;
    mem_addr_u   addr;
    logic [31:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic        ready;
    logic [31:0] rdata;
  } mem_rsp_t;

  typedef enum logic [1:0] {
    REG_RAM   = 2'd0,
    REG_TIMER = 2'd1,
    REG_NONE  = 2'd2
  } region_e;

  typedef struct packed {
    logic        en;
    logic [3:0]  strb;
    logic [17:0] widx;
    logic [31:0] data;
  } ram_wr_t;

endpackage

`default_nettype wire

// ==== design/prog_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

module prog_loader #(
  parameter int CLKS_PER_BIT = 8
) (
  input  logic                 clk_i,
  input  logic                 rst_n,
  input  logic                 rx_i,
  output logic                 sys_rst_n_o,
  output logic                 prog_mode_o,
  output soc_mem_pkg::ram_wr_t ram_wr_o
);
  import soc_mem_pkg::*;

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] BIT_END  = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] HALF_END = CNT_W'(CLKS_PER_BIT / 2 - 1);

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;
  typedef enum logic [1:0] {F_SYNC, F_CNT_LO, F_CNT_HI, F_DATA} frm_state_e;

  logic             rx_meta_q;
  logic             rx_q;
  rx_state_e        rx_state_q;
  logic [CNT_W-1:0] clk_cnt_q;
  logic             cnt_end;
  logic [2:0]       bit_idx_q;
  logic [7:0]       shift_q;
  logic             stop_evt;
  frm_state_e       frm_state_q;
  logic [7:0]       cnt_lo_q;
  logic [15:0]      words_left_q;
  logic [1:0]       byte_idx_q;
  logic [23:0]      word_lo_q;
  logic [31:0]      wdata_q;
  logic [17:0]      widx_q;
  logic             wr_en_q;
  logic             wr_last_q;
  logic             sys_rst_n_q;

  //////////////////////////////////////////////////
  // Serial receiver, 8N1
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      rx_meta_q <= 1'b1;
      rx_q      <= 1'b1;
    end else begin
      rx_meta_q <= rx_i;
      rx_q      <= rx_meta_q;
    end
  end

  assign cnt_end  = (rx_state_q == RX_START) ? (clk_cnt_q == HALF_END) : (clk_cnt_q == BIT_END);
  assign stop_evt = (rx_state_q == RX_STOP) && cnt_end;

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      rx_state_q <= RX_IDLE;
      clk_cnt_q  <= '0;
      bit_idx_q  <= '0;
    end else if (rx_state_q == RX_IDLE) begin
      clk_cnt_q <= '0;
      if (!rx_q) rx_state_q <= RX_START;
    end else if (!cnt_end) begin
      clk_cnt_q <= clk_cnt_q + CNT_W'(1);
    end else begin
      clk_cnt_q <= '0;
      unique case (rx_state_q)
        // Mid start bit, a high line here was a glitch
        RX_START: begin
          bit_idx_q  <= '0;
          rx_state_q <= rx_q ? RX_IDLE : RX_DATA;
        end
        RX_DATA: begin
          bit_idx_q <= bit_idx_q + 3'd1;
          if (bit_idx_q == 3'd7) rx_state_q <= RX_STOP;
        end
        default: rx_state_q <= RX_IDLE;
      endcase
    end
  end

  // LSB arrives first
  always_ff @(posedge clk_i) begin
    if (rx_state_q == RX_DATA && cnt_end) shift_q <= {rx_q, shift_q[7:1]};
  end

  //////////////////////////////////////////////////
  // Frame parser and word writer
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      frm_state_q  <= F_SYNC;
      sys_rst_n_q  <= 1'b1;
      wr_en_q      <= 1'b0;
      wr_last_q    <= 1'b0;
      cnt_lo_q     <= '0;
      words_left_q <= '0;
      byte_idx_q   <= '0;
      widx_q       <= '0;
    end else begin
      wr_en_q <= 1'b0;
      if (wr_en_q) begin
        widx_q <= widx_q + 18'd1;
        if (wr_last_q) sys_rst_n_q <= 1'b1;
      end
      if (stop_evt && !rx_q) begin
        // Bad stop bit, give up on the frame
        frm_state_q <= F_SYNC;
        sys_rst_n_q <= 1'b1;
      end else if (stop_evt) begin
        unique case (frm_state_q)
          F_SYNC: if (shift_q == LOAD_SYNC) begin
            frm_state_q <= F_CNT_LO;
            sys_rst_n_q <= 1'b0;
            widx_q      <= '0;
          end
          F_CNT_LO: begin
            cnt_lo_q    <= shift_q;
            frm_state_q <= F_CNT_HI;
          end
          F_CNT_HI: begin
            words_left_q <= {shift_q, cnt_lo_q};
            byte_idx_q   <= '0;
            if ({shift_q, cnt_lo_q} == 16'd0) begin
              frm_state_q <= F_SYNC;
              sys_rst_n_q <= 1'b1;
            end else begin
              frm_state_q <= F_DATA;
            end
          end
          default: begin
            byte_idx_q <= byte_idx_q + 2'd1;
            if (byte_idx_q == 2'd3) begin
              wr_en_q      <= 1'b1;
              wr_last_q    <= (words_left_q == 16'd1);
              words_left_q <= words_left_q - 16'd1;
              if (words_left_q == 16'd1) frm_state_q <= F_SYNC;
            end
          end
        endcase
      end
    end
  end

  // Little-endian word assembly
  always_ff @(posedge clk_i) begin
    if (stop_evt && frm_state_q == F_DATA) begin
      word_lo_q <= {shift_q, word_lo_q[23:8]};
      if (byte_idx_q == 2'd3) wdata_q <= {shift_q, word_lo_q};
    end
  end

  assign sys_rst_n_o = sys_rst_n_q;
  assign prog_mode_o = ~sys_rst_n_q;
  assign ram_wr_o    = '{en: wr_en_q, strb: 4'hF, widx: widx_q, data: wdata_q};

  a_wr_in_prog_mode : assert property (@(posedge clk_i) disable iff (!rst_n)
    ram_wr_o.en |-> prog_mode_o);

endmodule

`default_nettype wire

// ==== design/bus_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_decoder #(
  parameter int RAM_WORDS   = 1024,
  parameter int RAM_LATENCY = 4
) (
  input  logic                  clk_i,
  input  logic                  rst_n,
  input  soc_mem_pkg::mem_req_t req_i,
  output soc_mem_pkg::region_e  region_o,
  output logic                  ready_o,
  output soc_mem_pkg::ram_wr_t  ram_wr_o,
  output logic [17:0]           ram_ridx_o
);
  import soc_mem_pkg::*;

  localparam int CW = $clog2(RAM_LATENCY + 1);
  localparam logic [11:0] RAM_TAG      = RAM_BASE[31:20];
  localparam logic [15:0] TIMER_PAGE   = TIMER_LO_ADDR[31:16];
  localparam logic [13:0] TIMER_LO_REG = TIMER_LO_ADDR[15:2];
  localparam logic [13:0] TIMER_HI_REG = TIMER_HI_ADDR[15:2];

  logic          ram_hit;
  logic          timer_hit;
  logic          ram_start;
  logic          ram_done;
  logic          busy_q;
  logic [CW-1:0] lat_cnt_q;
  logic          none_q;

  if (RAM_LATENCY < 2) begin : g_lat_check
    $error("RAM_LATENCY below 2 leaves no time for the registered read");
  end
  if (RAM_WORDS * 4 > RAM_REGION_MASK + 1) begin : g_size_check
    $error("RAM_WORDS does not fit in the RAM region");
  end

  //////////////////////////////////////////////////
  // Region decode
  //////////////////////////////////////////////////

  assign ram_hit   = (req_i.addr.ram_view.tag == RAM_TAG);
  assign timer_hit = (req_i.addr.io_view.page == TIMER_PAGE) &&
                     (req_i.addr.io_view.boff == 2'b00) &&
                     ((req_i.addr.io_view.ridx == TIMER_LO_REG) ||
                      (req_i.addr.io_view.ridx == TIMER_HI_REG));

  always_comb begin
    if (ram_hit) region_o = REG_RAM;
    else if (timer_hit) region_o = REG_TIMER;
    else region_o = REG_NONE;
  end

  //////////////////////////////////////////////////
  // RAM latency and ready
  //////////////////////////////////////////////////

  // Only the first cycle of a RAM request starts the count
  assign ram_start = req_i.valid && (region_o == REG_RAM) && !busy_q;
  assign ram_done  = busy_q && (lat_cnt_q == CW'(RAM_LATENCY));

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      busy_q    <= 1'b0;
      lat_cnt_q <= '0;
      none_q    <= 1'b0;
    end else begin
      if (ram_start) begin
        busy_q    <= 1'b1;
        lat_cnt_q <= CW'(1);
      end else if (ram_done) begin
        busy_q <= 1'b0;
      end else if (busy_q) begin
        lat_cnt_q <= lat_cnt_q + CW'(1);
      end
      // Unmapped requests finish one cycle later
      none_q <= req_i.valid && (region_o == REG_NONE) && !none_q;
    end
  end

  assign ready_o = ram_done || none_q || (req_i.valid && (region_o == REG_TIMER));

  // Write goes out once, at request start
  assign ram_wr_o = '{
    en:   ram_start && (req_i.wstrb != 4'h0),
    strb: req_i.wstrb,
    widx: req_i.addr.ram_view.widx,
    data: req_i.wdata
  };
  assign ram_ridx_o = req_i.addr.ram_view.widx;

  a_ready_needs_valid : assert property (@(posedge clk_i) disable iff (!rst_n)
    ready_o |-> req_i.valid);

  a_widx_in_range : assert property (@(posedge clk_i) disable iff (!rst_n)
    (req_i.valid && (region_o == REG_RAM)) |-> (32'(ram_ridx_o) < RAM_WORDS));

endmodule

`default_nettype wire

// ==== design/byte_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module byte_ram #(
  parameter int RAM_WORDS = 1024
) (
  input  logic                 clk_i,
  input  soc_mem_pkg::ram_wr_t wr_i,
  input  logic [17:0]          ridx_i,
  output logic [31:0]          rdata_o
);

  localparam int AW = $clog2(RAM_WORDS);

  logic [31:0]   mem [RAM_WORDS];
  logic [AW-1:0] waddr;
  logic [AW-1:0] raddr;

  if (RAM_WORDS > 2**18) begin : g_depth_check
    $error("RAM_WORDS exceeds the 18-bit word index");
  end

  //////////////////////////////////////////////////
  // Word array with byte lanes
  //////////////////////////////////////////////////

  assign waddr = wr_i.widx[AW-1:0];
  assign raddr = ridx_i[AW-1:0];

  always_ff @(posedge clk_i) begin
    if (wr_i.en) begin
      for (int b = 0; b < 4; b++) begin
        if (wr_i.strb[b]) begin
          mem[waddr][8*b +: 8] <= wr_i.data[8*b +: 8];
        end
      end
    end
  end

  // Read port is sampled every cycle
  always_ff @(posedge clk_i) begin
    rdata_o <= mem[raddr];
  end

endmodule

`default_nettype wire

// ==== design/io_read_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

module io_read_mux (
  input  logic                  clk_i,
  input  logic                  rst_n,
  input  soc_mem_pkg::mem_req_t req_i,
  input  soc_mem_pkg::region_e  region_i,
  input  logic                  ready_i,
  input  logic [31:0]           ram_rdata_i,
  output soc_mem_pkg::mem_rsp_t rsp_o
);
  import soc_mem_pkg::*;

  logic [63:0] timer_q;
  logic [31:0] timer_word;
  logic [31:0] rdata;

  //////////////////////////////////////////////////
  // Free-running cycle timer
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      timer_q <= '0;
    end else begin
      timer_q <= timer_q + 64'd1;
    end
  end

  // Register index 1 is the high word
  assign timer_word = req_i.addr.io_view.ridx[0] ? timer_q[63:32] : timer_q[31:0];

  always_comb begin
    unique case (region_i)
      REG_RAM:   rdata = ram_rdata_i;
      REG_TIMER: rdata = timer_word;
      default:   rdata = '0;
    endcase
  end

  assign rsp_o = '{ready: ready_i, rdata: rdata};

endmodule

`default_nettype wire

// ==== design/mem_subsys_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top #(
  parameter int RAM_WORDS    = 1024,
  parameter int RAM_LATENCY  = 4,
  parameter int CLKS_PER_BIT = 8
) (
  input  logic                  clk_i,
  input  logic                  rst_n,
  input  logic                  prog_rx_i,
  output logic                  prog_mode_o,
  input  soc_mem_pkg::mem_req_t bus_req_i,
  output soc_mem_pkg::mem_rsp_t bus_rsp_o
);
  import soc_mem_pkg::*;

  logic        sys_rst_n;
  logic        core_rst_n;
  ram_wr_t     ldr_wr;
  ram_wr_t     dec_wr;
  ram_wr_t     ram_wr;
  region_e     region;
  logic        dec_ready;
  logic [17:0] ram_ridx;
  logic [31:0] ram_rdata;

  // Bus side stays in reset while a program is loading
  assign core_rst_n = rst_n & sys_rst_n;

  // Loader owns the RAM write port during a load
  assign ram_wr = sys_rst_n ? dec_wr : ldr_wr;

  prog_loader #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_loader (
    .clk_i       (clk_i),
    .rst_n       (rst_n),
    .rx_i        (prog_rx_i),
    .sys_rst_n_o (sys_rst_n),
    .prog_mode_o (prog_mode_o),
    .ram_wr_o    (ldr_wr)
  );

  bus_decoder #(
    .RAM_WORDS   (RAM_WORDS),
    .RAM_LATENCY (RAM_LATENCY)
  ) u_decoder (
    .clk_i      (clk_i),
    .rst_n      (core_rst_n),
    .req_i      (bus_req_i),
    .region_o   (region),
    .ready_o    (dec_ready),
    .ram_wr_o   (dec_wr),
    .ram_ridx_o (ram_ridx)
  );

  byte_ram #(
    .RAM_WORDS (RAM_WORDS)
  ) u_ram (
    .clk_i   (clk_i),
    .wr_i    (ram_wr),
    .ridx_i  (ram_ridx),
    .rdata_o (ram_rdata)
  );

  io_read_mux u_rdmux (
    .clk_i       (clk_i),
    .rst_n       (core_rst_n),
    .req_i       (bus_req_i),
    .region_i    (region),
    .ready_i     (dec_ready),
    .ram_rdata_i (ram_rdata),
    .rsp_o       (bus_rsp_o)
  );

endmodule

`default_nettype wire

// ==== dv/tb_mem_subsys.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys;
  import soc_mem_pkg::*;

  localparam int RAM_WORDS    = 1024;
  localparam int RAM_LATENCY  = 4;
  localparam int CLKS_PER_BIT = 8;
  localparam int RESET_CYCLES = 8;
  localparam int LOAD_WORDS   = 16;
  localparam int NUM_WR       = 24;
  localparam int NUM_UNMAPPED = 4;
  localparam int TIMER_WAIT   = 40;
  // Ten bit times per byte plus the idle gap the driver leaves
  localparam int FRAME_CYCLES = (3 + 4 * LOAD_WORDS) * (10 * CLKS_PER_BIT + 2);
  localparam int N_XFERS      = 2 * LOAD_WORDS + 4 * NUM_WR + NUM_UNMAPPED + 2;
  localparam int TIMEOUT_CYCLES =
    2 * (RESET_CYCLES + FRAME_CYCLES + TIMER_WAIT + N_XFERS * (RAM_LATENCY + 4));

  logic        clk;
  logic        rst_n;
  logic        prog_rx;
  logic        prog_mode;
  mem_req_t    bus_req;
  mem_rsp_t    bus_rsp;
  logic [31:0] rng;
  logic [31:0] mem_model [int];
  int          cycle_cnt   = 0;
  int          fall_cycle  = 0;
  int          ready_cycle = 0;
  logic        prog_prev   = 1'b0;

  mem_subsys_top #(
    .RAM_WORDS    (RAM_WORDS),
    .RAM_LATENCY  (RAM_LATENCY),
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) dut (
    .clk_i       (clk),
    .rst_n       (rst_n),
    .prog_rx_i   (prog_rx),
    .prog_mode_o (prog_mode),
    .bus_req_i   (bus_req),
    .bus_rsp_o   (bus_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      $display("ERROR: run passed %0d cycles, a bus handshake or the loader hung",
               TIMEOUT_CYCLES);
      $display("Simulation finished: FAIL");
      $fatal(1, "timeout");
    end
  end

  // Remember the cycle in which the loader let go of the system reset
  always @(negedge clk) begin
    if (prog_prev && !prog_mode) fall_cycle = cycle_cnt;
    prog_prev = prog_mode;
    if (rst_n) begin
      check_eq("ready without valid", 32'd0, 32'(bus_rsp.ready & ~bus_req.valid));
    end
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] merge_lanes(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0]  strb);
    logic [31:0] res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

  task automatic check_eq(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
    if (actual !== expected) begin
      $display("FAILED %s: expected %h, actual %h", name, expected, actual);
      $display("Simulation finished: FAIL");
      $fatal(1, "check %s failed", name);
    end
  endtask

  task automatic uart_send_byte(input logic [7:0] data);
    logic [9:0] frame;
    // Start bit, data LSB first, stop bit
    frame = {1'b1, data, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      #1;
      prog_rx = frame[i];
      repeat (CLKS_PER_BIT - 1) @(posedge clk);
    end
    @(posedge clk);
    #1;
  endtask

  // lat counts clock edges between the first valid cycle and the ready cycle
  task automatic bus_xfer(input logic [31:0] addr, input logic [3:0] strb,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output int lat);
    @(posedge clk);
    #1;
    bus_req.valid = 1'b1;
    bus_req.wstrb = strb;
    bus_req.addr  = mem_addr_u'(addr);
    bus_req.wdata = wdata;
    lat = 0;
    @(negedge clk);
    while (!bus_rsp.ready) begin
      @(negedge clk);
      lat++;
    end
    rdata = bus_rsp.rdata;
    ready_cycle = cycle_cnt;
    @(posedge clk);
    #1;
    bus_req = '0;
    @(negedge clk);
    check_eq("ready pulse width", 32'd0, 32'(bus_rsp.ready));
  endtask

  task automatic ram_write(input int idx, input logic [3:0] strb, input logic [31:0] data);
    logic [31:0] rdata;
    logic [31:0] old_w;
    int          lat;
    old_w = mem_model.exists(idx) ? mem_model[idx] : 32'h0;
    bus_xfer(RAM_BASE + 32'(idx * 4), strb, data, rdata, lat);
    check_eq("ram write latency", 32'(RAM_LATENCY), 32'(lat));
    mem_model[idx] = merge_lanes(old_w, data, strb);
  endtask

  task automatic ram_check(input int idx, input string name);
    logic [31:0] rdata;
    int          lat;
    bus_xfer(RAM_BASE + 32'(idx * 4), 4'h0, 32'h0, rdata, lat);
    check_eq("ram read latency", 32'(RAM_LATENCY), 32'(lat));
    check_eq(name, mem_model[idx], rdata);
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    logic [31:0] rdata;
    logic [31:0] addr;
    logic [31:0] word;
    logic [3:0]  strb;
    int          lat;
    int          idx;
    int          wait_n;

    rng     = 32'hfc4ab0cc;
    rst_n   = 1'b0;
    prog_rx = 1'b1;
    bus_req = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check_eq("prog_mode after reset", 32'd0, 32'(prog_mode));

    // Program load
    for (int i = 0; i < LOAD_WORDS; i++) begin
      rng = xorshift32(rng);
      mem_model[i] = rng;
    end
    uart_send_byte(LOAD_SYNC);
    @(negedge clk);
    check_eq("prog_mode during frame", 32'd1, 32'(prog_mode));
    uart_send_byte(8'(LOAD_WORDS));
    uart_send_byte(8'(LOAD_WORDS >> 8));
    for (int i = 0; i < LOAD_WORDS; i++) begin
      word = mem_model[i];
      for (int b = 0; b < 4; b++) begin
        // System reset is still held until the last word is written
        if (i == LOAD_WORDS - 1 && b == 3) begin
          @(negedge clk);
          check_eq("prog_mode before last byte", 32'd1, 32'(prog_mode));
        end
        uart_send_byte(word[8*b +: 8]);
      end
    end
    // Loader lets go within one bit time of the last stop bit
    repeat (CLKS_PER_BIT) begin
      if (prog_mode) @(negedge clk);
    end
    check_eq("prog_mode after frame", 32'd0, 32'(prog_mode));

    // Timer counts cycles since the loader released reset
    rng = xorshift32(rng);
    wait_n = 3 + int'(rng[4:0]);
    repeat (wait_n) @(posedge clk);
    bus_xfer(TIMER_LO_ADDR, 4'h0, 32'h0, rdata, lat);
    check_eq("timer low latency", 32'd0, 32'(lat));
    check_eq("timer low value", 32'(ready_cycle - fall_cycle), rdata);
    bus_xfer(TIMER_HI_ADDR, 4'h0, 32'h0, rdata, lat);
    check_eq("timer high latency", 32'd0, 32'(lat));
    check_eq("timer high value", 32'd0, rdata);

    for (int i = 0; i < LOAD_WORDS; i++) begin
      ram_check(i, "load readback");
    end

    // Random byte writes
    for (int n = 0; n < NUM_WR; n++) begin
      rng = xorshift32(rng);
      idx = int'(rng % RAM_WORDS);
      if (!mem_model.exists(idx)) begin
        rng = xorshift32(rng);
        ram_write(idx, 4'hF, rng);
      end
      rng = xorshift32(rng);
      strb = rng[3:0];
      if (strb == 4'h0) strb = 4'h8;
      rng = xorshift32(rng);
      ram_write(idx, strb, rng);
      ram_check(idx, "byte write readback");
    end

    // Unmapped addresses whose low bits alias a loaded word
    for (int n = 0; n < NUM_UNMAPPED; n++) begin
      rng = xorshift32(rng);
      addr = rng;
      while (addr[31:20] == RAM_BASE[31:20] || addr[31:16] == TIMER_LO_ADDR[31:16]) begin
        rng = xorshift32(rng);
        addr = rng;
      end
      addr[11:2] = {6'd0, addr[5:2]};
      rng = xorshift32(rng);
      strb = (n % 2 == 1) ? (rng[3:0] | 4'h1) : 4'h0;
      bus_xfer(addr, strb, rng, rdata, lat);
      check_eq("unmapped latency", 32'd1, 32'(lat));
      check_eq("unmapped rdata", 32'd0, rdata);
    end
    foreach (mem_model[k]) begin
      ram_check(k, "readback after unmapped");
    end

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
design/soc_mem_pkg.sv
design/prog_loader.sv
design/bus_decoder.sv
design/byte_ram.sv
design/io_read_mux.sv
design/mem_subsys_top.sv
dv/tb_mem_subsys.sv

// ==== run_sim.sh ====
#!/bin/bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
{ verilator --binary --timing --timescale 1ns/1ps --top-module tb_mem_subsys \
    -f files.f \
  && ./obj_dir/Vtb_mem_subsys; } > sim.log 2>&1 \
  || echo "Simulation finished: FAIL" >> sim.log
cat sim.log
if grep -q "Simulation finished: FAIL" sim.log; then
  exit 1
fi
grep -q "Simulation finished: PASS" sim.log || exit 1
exit 0
